// ==== all.f ====
+incdir+include
design/beam_pkg.sv
design/channel_weighter.sv
design/beat_fifo.sv
design/beam_summer.sv
design/beamformer_top.sv
test/beamformer_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the beamformer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module beamformer_tb -f all.f

result=$(./obj_dir/Vbeamformer_tb 2>&1) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'TESTS PASSED'; then
    exit 0
else
    exit 1
fi

// ==== include/beam_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench helpers for the beamformer
// LFSR random source and a plain integer model of the
// weighting and beam sum, included inside the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BEAM_MODEL_SVH
`define BEAM_MODEL_SVH

// fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// one step per bit, newest bit lands in bit 0 of the result
function automatic logic [31:0] lfsr_take(inout logic [31:0] state,
                                          input int unsigned nbits);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned n = 0; n < nbits; n++) begin
        state = lfsr_step(state);
        bits  = {bits[30:0], state[0]};
    end
    return bits;
endfunction

// one channel through the weighter, done in 64-bit integers
function automatic beam_pkg::beat_t model_weight(input beam_pkg::beat_t      x,
                                                 input beam_pkg::cplx_weight_t w);
    beam_pkg::beat_t y;
    longint          pr;
    longint          pi;
    for (int lane = 0; lane < beam_pkg::LANES; lane++) begin
        pr = longint'(w.re) * longint'(x.re[lane]) - longint'(w.im) * longint'(x.im[lane]);
        pi = longint'(w.re) * longint'(x.im[lane]) + longint'(w.im) * longint'(x.re[lane]);
        y.re[lane] = beam_pkg::sample_t'(pr >>> beam_pkg::WEIGHT_FRAC);
        y.im[lane] = beam_pkg::sample_t'(pi >>> beam_pkg::WEIGHT_FRAC);
    end
    y.last = x.last;
    return y;
endfunction

// expected output beat from the raw input beats of all channels
function automatic beam_pkg::beat_t model_beam(
    input beam_pkg::beat_t [beam_pkg::CHANNELS-1:0]        x,
    input beam_pkg::cplx_weight_t [beam_pkg::CHANNELS-1:0] w
);
    beam_pkg::beat_t                                 y;
    beam_pkg::beat_t [beam_pkg::CHANNELS-1:0]        wb;
    longint                                          acc_re;
    longint                                          acc_im;
    for (int ch = 0; ch < beam_pkg::CHANNELS; ch++) begin
        wb[ch] = model_weight(x[ch], w[ch]);
    end
    for (int lane = 0; lane < beam_pkg::LANES; lane++) begin
        acc_re = 0;
        acc_im = 0;
        for (int ch = 0; ch < beam_pkg::CHANNELS; ch++) begin
            acc_re += longint'(wb[ch].re[lane]);
            acc_im += longint'(wb[ch].im[lane]);
        end
        y.re[lane] = beam_pkg::sample_t'(acc_re >>> beam_pkg::SUM_SHIFT);
        y.im[lane] = beam_pkg::sample_t'(acc_im >>> beam_pkg::SUM_SHIFT);
    end
    // channel 0 owns the last flag
    y.last = x[0].last;
    return y;
endfunction

`endif

// ==== test/beamformer_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the four-channel beamformer
// random per-channel senders and random output stalls feed
// a scoreboard that pops one beat per channel per output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module beamformer_tb;
    import beam_pkg::*;

    `include "beam_model.svh"

    logic                         clock;
    logic                         resetn;
    cplx_weight_t [CHANNELS-1:0]  weights;
    logic [CHANNELS-1:0]          s_valid;
    beat_t [CHANNELS-1:0]         s_beat;
    logic [CHANNELS-1:0]          s_ready;
    logic                         m_valid;
    beat_t                        m_beat;
    logic                         m_ready;

    logic [31:0]          lfsr_state;
    // accepted beats per channel, oldest first
    beat_t                sent_q [CHANNELS][$];
    int                   to_send [CHANNELS];
    int                   gap [CHANNELS];
    // handshake seen just before the coming edge
    logic [CHANNELS-1:0]  s_fire;
    // traffic shape of the running phase
    int                   max_gap;
    bit                   extremes;
    bit                   stall_mode;
    bit                   single_mode;
    int                   out_count;
    // output was stalled at the previous sample
    logic                 hold_pending;
    beat_t                held_beat;

    beamformer_top #(
        .FIFO_DEPTH (4)
    ) beamformer_top_inst (
        .clock   (clock),
        .resetn  (resetn),
        .weights (weights),
        .s_valid (s_valid),
        .s_beat  (s_beat),
        .s_ready (s_ready),
        .m_valid (m_valid),
        .m_beat  (m_beat),
        .m_ready (m_ready)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] rand_bits(input int unsigned nbits);
        return lfsr_take(lfsr_state, nbits);
    endfunction

    // mostly uniform with an occasional corner value
    function automatic sample_t random_sample(input bit ext);
        logic [31:0] pick;
        logic [31:0] val;
        pick = rand_bits(3);
        val  = rand_bits(16);
        if (ext && pick[2:0] == 3'd0) begin
            case (val[1:0])
                2'd0:    val[15:0] = 16'h8000;
                2'd1:    val[15:0] = 16'h7fff;
                2'd2:    val[15:0] = 16'hffff;
                default: val[15:0] = 16'h0000;
            endcase
        end
        return sample_t'(val[15:0]);
    endfunction

    function automatic weight_t random_part(input bit ext);
        logic [31:0] pick;
        logic [31:0] val;
        pick = rand_bits(2);
        val  = rand_bits(8);
        if (ext && pick[1:0] == 2'd0) begin
            case (val[1:0])
                2'd0:    val[7:0] = 8'h80;
                2'd1:    val[7:0] = 8'h7f;
                2'd2:    val[7:0] = 8'hff;
                default: val[7:0] = 8'h00;
            endcase
        end
        return weight_t'(val[7:0]);
    endfunction

    function automatic beat_t random_beat(input bit ext);
        beat_t        b;
        logic [31:0]  r;
        for (int lane = 0; lane < LANES; lane++) begin
            b.re[lane] = random_sample(ext);
            b.im[lane] = random_sample(ext);
        end
        r      = rand_bits(1);
        b.last = r[0];
        return b;
    endfunction

    // pop the channel heads and compare against the model
    task automatic check_output();
        beat_t [CHANNELS-1:0]  heads;
        beat_t                 expected;
        beat_t                 ch0_only;
        sample_t               lane_exp;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            assert (sent_q[ch].size() > 0) else report_failure($sformatf(
                "output beat %0d arrived with no input left on channel %0d", out_count, ch));
            heads[ch] = sent_q[ch].pop_front();
        end
        expected = model_beam(heads, weights);
        assert (m_beat.re == expected.re) else report_failure($sformatf(
            "mismatch m_beat.re beat %0d exp %h got %h", out_count, expected.re, m_beat.re));
        assert (m_beat.im == expected.im) else report_failure($sformatf(
            "mismatch m_beat.im beat %0d exp %h got %h", out_count, expected.im, m_beat.im));
        assert (m_beat.last == expected.last) else report_failure($sformatf(
            "mismatch m_beat.last beat %0d exp %h got %h", out_count, expected.last,
            m_beat.last));
        // other weights are zero, so the beam is channel 0 alone
        if (single_mode) begin
            ch0_only = model_weight(heads[0], weights[0]);
            for (int lane = 0; lane < LANES; lane++) begin
                lane_exp = sample_t'(ch0_only.re[lane] >>> SUM_SHIFT);
                assert (m_beat.re[lane] == lane_exp) else report_failure($sformatf(
                    "mismatch m_beat.re lane %0d exp %h got %h", lane, lane_exp,
                    m_beat.re[lane]));
                lane_exp = sample_t'(ch0_only.im[lane] >>> SUM_SHIFT);
                assert (m_beat.im[lane] == lane_exp) else report_failure($sformatf(
                    "mismatch m_beat.im lane %0d exp %h got %h", lane, lane_exp,
                    m_beat.im[lane]));
            end
        end
        out_count++;
    endtask

    // drive 1 ns after the edge, sample 1 ns before the next one
    task automatic run_cycle();
        logic [31:0] r;
        @(posedge clock);
        #1;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            if (s_fire[ch]) begin
                s_valid[ch] = 1'b0;
                gap[ch]     = int'(rand_bits(3) % (max_gap + 1));
            end
            if (!s_valid[ch] && to_send[ch] > 0) begin
                if (gap[ch] == 0) begin
                    s_beat[ch]  = random_beat(extremes);
                    s_valid[ch] = 1'b1;
                end else begin
                    gap[ch]--;
                end
            end
        end
        r       = rand_bits(1);
        m_ready = stall_mode ? r[0] : 1'b1;
        #2;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            s_fire[ch] = s_valid[ch] && s_ready[ch];
            if (s_fire[ch]) begin
                sent_q[ch].push_back(s_beat[ch]);
                to_send[ch]--;
            end
        end
        // stalled output must hold still
        if (hold_pending) begin
            assert (m_valid) else report_failure($sformatf(
                "mismatch m_valid under stall exp %h got %h", 1'b1, m_valid));
            assert (m_beat == held_beat) else report_failure($sformatf(
                "mismatch m_beat under stall exp %h got %h", held_beat, m_beat));
        end
        hold_pending = m_valid && !m_ready;
        held_beat    = m_beat;
        if (m_valid && m_ready) begin
            check_output();
        end
    endtask

    task automatic idle_cycles(input int n);
        stall_mode = 1'b0;
        repeat (n) run_cycle();
    endtask

    // new weights only while nothing is in flight
    task automatic load_weights(input cplx_weight_t [CHANNELS-1:0] w);
        @(posedge clock);
        #1;
        weights = w;
        #2;
        idle_cycles(2);
    endtask

    function automatic bit all_sent();
        for (int ch = 0; ch < CHANNELS; ch++) begin
            if (to_send[ch] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic run_phase(input string name, input int beats, input int gap_max,
                             input int start_max, input bit stall, input bit ext,
                             input bit single);
        int  cycles;
        bit  done;
        max_gap     = gap_max;
        extremes    = ext;
        stall_mode  = stall;
        single_mode = single;
        out_count   = 0;
        // random start offsets give channel skew
        for (int ch = 0; ch < CHANNELS; ch++) begin
            to_send[ch] = beats;
            gap[ch]     = int'(rand_bits(4) % (start_max + 1));
        end
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            run_cycle();
            cycles++;
            done = all_sent() && (out_count == beats);
            if (!done && cycles >= beats * 40 + 100) begin
                report_failure($sformatf("timeout in phase %s after %0d cycles, %0d beats out",
                                         name, cycles, out_count));
            end
        end
        // an extra output beat here finds every channel queue empty
        idle_cycles(6);
    endtask

    initial begin
        cplx_weight_t [CHANNELS-1:0] w;
        lfsr_state   = 32'hb9a7_5b92;
        resetn       = 1'b0;
        weights      = '0;
        s_valid      = '0;
        s_beat       = '0;
        m_ready      = 1'b0;
        s_fire       = '0;
        hold_pending = 1'b0;
        held_beat    = '0;
        max_gap      = 0;
        extremes     = 1'b0;
        stall_mode   = 1'b0;
        single_mode  = 1'b0;
        out_count    = 0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            to_send[ch] = 0;
            gap[ch]     = 0;
        end

        // output stays quiet through reset and the first edge after it
        for (int i = 0; i < 2; i++) begin
            @(posedge clock);
            #1;
            assert (!m_valid) else report_failure($sformatf(
                "mismatch m_valid in reset exp %h got %h", 1'b0, m_valid));
        end
        resetn = 1'b1;
        @(posedge clock);
        #3;
        assert (!m_valid) else report_failure($sformatf(
            "mismatch m_valid after reset exp %h got %h", 1'b0, m_valid));

        // channel 0 only
        w    = '0;
        w[0] = {random_part(1'b0), random_part(1'b0)};
        load_weights(w);
        run_phase("single", 24, 2, 0, 1'b0, 1'b0, 1'b1);

        // all channels at full rate, corner values included
        for (int ch = 0; ch < CHANNELS; ch++) begin
            w[ch] = {random_part(1'b1), random_part(1'b1)};
        end
        w[2].re = 8'h80;
        w[3].im = 8'h80;
        load_weights(w);
        run_phase("full", 40, 0, 0, 1'b0, 1'b1, 1'b0);

        run_phase("skew", 40, 5, 12, 1'b0, 1'b1, 1'b0);
        run_phase("stall", 48, 1, 3, 1'b1, 1'b1, 1'b0);

        // drained above, so new weights are safe
        for (int ch = 0; ch < CHANNELS; ch++) begin
            w[ch] = {random_part(1'b0), random_part(1'b0)};
        end
        load_weights(w);
        run_phase("reweight", 32, 2, 4, 1'b1, 1'b0, 1'b0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/beamformer_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-channel complex beamformer
// each channel runs weighter then FIFO, and the summer joins
// them into one beam stream; weights change only when idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module beamformer_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                                                   clock,
    input  wire                                                   resetn,
    input  wire beam_pkg::cplx_weight_t [beam_pkg::CHANNELS-1:0]  weights,
    input  wire [beam_pkg::CHANNELS-1:0]                          s_valid,
    input  wire beam_pkg::beat_t [beam_pkg::CHANNELS-1:0]         s_beat,
    output logic [beam_pkg::CHANNELS-1:0]                         s_ready,
    output logic                                                  m_valid,
    output beam_pkg::beat_t                                       m_beat,
    input  wire                                                   m_ready
);
    import beam_pkg::*;

    // weighter to FIFO links
    wire [CHANNELS-1:0]         w_valid;
    wire [CHANNELS-1:0]         w_ready;
    wire beat_t [CHANNELS-1:0]  w_beat;

    // FIFO to summer links
    wire [CHANNELS-1:0]         f_valid;
    wire [CHANNELS-1:0]         f_ready;
    wire beat_t [CHANNELS-1:0]  f_beat;

    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel
        channel_weighter weighter_inst (
            .clock     (clock),
            .resetn    (resetn),
            .weight    (weights[ch]),
            .in_valid  (s_valid[ch]),
            .in_beat   (s_beat[ch]),
            .in_ready  (s_ready[ch]),
            .out_valid (w_valid[ch]),
            .out_beat  (w_beat[ch]),
            .out_ready (w_ready[ch])
        );

        beat_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) fifo_inst (
            .clock      (clock),
            .resetn     (resetn),
            .push_valid (w_valid[ch]),
            .push_beat  (w_beat[ch]),
            .push_ready (w_ready[ch]),
            .pop_valid  (f_valid[ch]),
            .pop_beat   (f_beat[ch]),
            .pop_ready  (f_ready[ch])
        );
    end

    beam_summer summer_inst (
        .clock    (clock),
        .resetn   (resetn),
        .ch_valid (f_valid),
        .ch_beat  (f_beat),
        .ch_ready (f_ready),
        .m_valid  (m_valid),
        .m_beat   (m_beat),
        .m_ready  (m_ready)
    );

endmodule

`default_nettype wire

// ==== design/beam_summer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// channel alignment and beam sum
// pops all channel FIFOs on the same edge, adds the weighted
// lanes at full width, scales by the channel count and
// registers one output beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module beam_summer (
    input  wire                                            clock,
    input  wire                                            resetn,
    input  wire [beam_pkg::CHANNELS-1:0]                   ch_valid,
    input  wire beam_pkg::beat_t [beam_pkg::CHANNELS-1:0]  ch_beat,
    output logic [beam_pkg::CHANNELS-1:0]                  ch_ready,
    output logic                                           m_valid,
    output beam_pkg::beat_t                                m_beat,
    input  wire                                            m_ready
);
    import beam_pkg::*;

    // one shared pop condition keeps beat k of every channel together
    logic   take;
    // scaled sum of the beats at the FIFO heads
    beat_t  sum_beat;

    assign take     = (&ch_valid) && (!m_valid || m_ready);
    assign ch_ready = {CHANNELS{take}};

    always_comb begin
        sample_t                      s_re;
        sample_t                      s_im;
        logic signed [SUM_WIDTH-1:0]  acc_re;
        logic signed [SUM_WIDTH-1:0]  acc_im;
        for (int lane = 0; lane < LANES; lane++) begin
            acc_re = '0;
            acc_im = '0;
            for (int ch = 0; ch < CHANNELS; ch++) begin
                s_re = ch_beat[ch].re[lane];
                s_im = ch_beat[ch].im[lane];
                // sign-extended into the wider accumulator
                acc_re = acc_re + s_re;
                acc_im = acc_im + s_im;
            end
            // floor-divide by the channel count, keep 16 bits
            sum_beat.re[lane] = sample_t'(acc_re >>> SUM_SHIFT);
            sum_beat.im[lane] = sample_t'(acc_im >>> SUM_SHIFT);
        end
        // channels are aligned, so channel 0 speaks for the frame end
        sum_beat.last = ch_beat[0].last;
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            m_valid <= 1'b0;
        end else if (!m_valid || m_ready) begin
            m_valid <= &ch_valid;
        end
    end

    // holds steady under back-pressure since take is low then
    always_ff @(posedge clock) begin
        if (take) begin
            m_beat <= sum_beat;
        end
    end

endmodule

`default_nettype wire

// ==== design/beat_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// small synchronous beat FIFO for one channel
// soaks up skew between channels and stalls from the summer
// push side and pop side both use ready/valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                   clock,
    input  wire                   resetn,
    input  wire                   push_valid,
    input  wire beam_pkg::beat_t  push_beat,
    output logic                  push_ready,
    output logic                  pop_valid,
    output beam_pkg::beat_t       pop_beat,
    input  wire                   pop_ready
);
    import beam_pkg::*;

    localparam int PTR_WIDTH   = $clog2(FIFO_DEPTH);
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    beat_t                   mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic [PTR_WIDTH-1:0]    rd_ptr;
    logic [COUNT_WIDTH-1:0]  count;
    logic                    push;
    logic                    pop;

    assign push_ready = (count != COUNT_WIDTH'(FIFO_DEPTH));
    assign pop_valid  = (count != '0);
    // registered storage, so no fall-through from push to pop
    assign pop_beat   = mem[rd_ptr];

    assign push = push_valid && push_ready;
    assign pop  = pop_valid && pop_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    // pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // occupancy, unchanged when push and pop meet
    always_ff @(posedge clock) begin
        if (!resetn) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/channel_weighter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// complex weighting of one antenna channel
// multiplies every lane of an accepted beat by the channel
// weight, rescales to 16 bits and holds it in a one-beat
// output register with ready/valid on both sides
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module channel_weighter (
    input  wire                          clock,
    input  wire                          resetn,
    input  wire beam_pkg::cplx_weight_t  weight,
    input  wire                          in_valid,
    input  wire beam_pkg::beat_t         in_beat,
    output logic                         in_ready,
    output logic                         out_valid,
    output beam_pkg::beat_t              out_beat,
    input  wire                          out_ready
);
    import beam_pkg::*;

    // weight is sampled every clock, so a change lands one cycle later
    cplx_weight_t weight_q;
    // weighted lanes of the beat on the input, before the register
    beat_t        weighted;

    always_ff @(posedge clock) begin
        weight_q <= weight;
    end

    // full-precision complex multiply per lane
    always_comb begin
        sample_t                       xr;
        sample_t                       xi;
        logic signed [PROD_WIDTH-1:0]  prod_re;
        logic signed [PROD_WIDTH-1:0]  prod_im;
        for (int lane = 0; lane < LANES; lane++) begin
            xr = in_beat.re[lane];
            xi = in_beat.im[lane];
            // real: wr*xr - wi*xi
            prod_re = weight_q.re * xr - weight_q.im * xi;
            // imag: wr*xi + wi*xr
            prod_im = weight_q.re * xi + weight_q.im * xr;
            // floor by the fraction bits, then wrap to 16 bits
            weighted.re[lane] = sample_t'(prod_re >>> WEIGHT_FRAC);
            weighted.im[lane] = sample_t'(prod_im >>> WEIGHT_FRAC);
        end
        // last flag rides along untouched
        weighted.last = in_beat.last;
    end

    // register is free when empty or being drained this edge
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only loads on an accepted beat
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            out_beat <= weighted;
        end
    end

endmodule

`default_nettype wire

// ==== design/beam_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// common widths and beat types for the beamformer datapath
// every design file and the testbench model pull their
// sample, weight and beat definitions from here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package beam_pkg;

    // bits in one real or imaginary sample part
    localparam int SAMPLE_WIDTH = 16;
    // bits in one weight part, signed fraction
    localparam int WEIGHT_WIDTH = 8;
    // fraction bits, so 1.0 is just out of range
    localparam int WEIGHT_FRAC = 7;
    // complex samples carried per beat
    localparam int LANES = 8;
    // antenna channels summed into one beam
    localparam int CHANNELS = 4;
    // divide the channel sum by the channel count
    localparam int SUM_SHIFT = 2;

    // full precision of wr*xr - wi*xi, one extra bit for the add
    localparam int PROD_WIDTH = SAMPLE_WIDTH + WEIGHT_WIDTH + 1;
    // full precision of the four-channel lane sum
    localparam int SUM_WIDTH = SAMPLE_WIDTH + $clog2(CHANNELS);

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // one channel weight, real part in the upper byte
    typedef struct packed {
        weight_t re;
        weight_t im;
    } cplx_weight_t;

    // lane 0 sits in the low bits of re and im
    typedef struct packed {
        sample_t [LANES-1:0] re;
        sample_t [LANES-1:0] im;
        logic                last;
    } beat_t;

endpackage

`default_nettype wire
